// ==== source/soc_bus_pkg.sv ====
package soc_bus_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  be_t;

    // Address bits 31..28
    typedef logic [3:0]  region_t;

    // Register offset inside a peripheral
    typedef logic [7:0]  reg_off_t;

    typedef struct packed {
        addr_t addr;
        data_t wdata;
        be_t   be;
        logic  rd;
        logic  wr;
    } bus_req_t;

    localparam region_t REGION_RAM    = 4'h0;
    localparam region_t REGION_GPIO   = 4'h1;
    localparam region_t REGION_TICKER = 4'h2;

    // Enabled lanes take the new byte, the rest keep the old one
    function automatic data_t be_merge(data_t old_word, data_t new_word, be_t be);
        data_t merged;
        for (int i = 0; i < 4; i++) begin
            merged[8*i +: 8] = be[i] ? new_word[8*i +: 8] : old_word[8*i +: 8];
        end
        return merged;
    endfunction

endpackage

// ==== source/dbus_decode.sv ====
`timescale 1ns/1ps

module dbus_decode import soc_bus_pkg::*; (
    input  logic     clk_bus,
    input  logic     reset_i,
    input  bus_req_t master_req_i,
    output data_t    master_rdata_o,
    output logic     master_stall_o,
    output bus_req_t ram_req_o,
    input  data_t    ram_rdata_i,
    input  logic     ram_stall_i,
    output bus_req_t gpio_req_o,
    input  data_t    gpio_rdata_i,
    output bus_req_t ticker_req_o,
    input  data_t    ticker_rdata_i
);

    region_t  region;
    logic     sel_ram;
    logic     sel_gpio;
    logic     sel_ticker;
    logic     reg_read;
    logic     reg_stall;
    logic     reg_pending;
    bus_req_t reg_req;

    assign region     = master_req_i.addr[31:28];
    assign sel_ram    = (region == REGION_RAM);
    assign sel_gpio   = (region == REGION_GPIO);
    assign sel_ticker = (region == REGION_TICKER);

    // Register targets only see the low address byte
    always_comb begin
        reg_req      = master_req_i;
        reg_req.addr = {24'b0, master_req_i.addr[7:0]};
    end

    always_comb begin
        ram_req_o       = master_req_i;
        ram_req_o.rd    = master_req_i.rd & sel_ram;
        ram_req_o.wr    = master_req_i.wr & sel_ram;
        gpio_req_o      = reg_req;
        gpio_req_o.rd   = master_req_i.rd & sel_gpio;
        gpio_req_o.wr   = master_req_i.wr & sel_gpio;
        ticker_req_o    = reg_req;
        ticker_req_o.rd = master_req_i.rd & sel_ticker;
        ticker_req_o.wr = master_req_i.wr & sel_ticker;
    end

    // Register read data comes one cycle after the strobe
    assign reg_read  = master_req_i.rd & (sel_gpio | sel_ticker);
    assign reg_stall = reg_read & ~reg_pending;

    always_ff @(posedge clk_bus) begin
        if (reset_i) begin
            reg_pending <= 1'b0;
        end else begin
            reg_pending <= reg_stall;
        end
    end

    assign master_stall_o = ram_stall_i | reg_stall;

    // Unmapped regions read as zero
    always_comb begin
        case (region)
            REGION_RAM:    master_rdata_o = ram_rdata_i;
            REGION_GPIO:   master_rdata_o = gpio_rdata_i;
            REGION_TICKER: master_rdata_o = ticker_rdata_i;
            default:       master_rdata_o = '0;
        endcase
    end

    // Master side of the protocol
    a_one_strobe: assert property (@(posedge clk_bus) disable iff (reset_i)
        !(master_req_i.rd && master_req_i.wr))
        else $error("dbus_decode: read and write strobes high together");

endmodule

// ==== source/bytes_conv.sv ====
`timescale 1ns/1ps

module bytes_conv import soc_bus_pkg::*; #(
    parameter int RAM_WORDS = 1024
) (
    input  logic                         clk_bus,
    input  logic                         reset_i,
    input  bus_req_t                     req_i,
    output data_t                        rdata_o,
    output logic                         stall_o,
    output logic [$clog2(RAM_WORDS)-1:0] mem_addr_o,
    output logic                         mem_we_o,
    output data_t                        mem_wdata_o,
    input  data_t                        mem_rdata_i
);

    localparam int IDX_W = $clog2(RAM_WORDS);

    typedef enum logic [1:0] {
        CONV_IDLE,
        CONV_READ,
        CONV_MERGE
    } conv_state_t;

    conv_state_t state;
    conv_state_t state_next;
    data_t       held_word;
    logic        full_write;
    logic        partial_write;

    // Zero byte enables also take the merge path, writing the old word back
    assign full_write    = req_i.wr & (req_i.be == 4'hf);
    assign partial_write = req_i.wr & (req_i.be != 4'hf);

    assign mem_addr_o = req_i.addr[IDX_W+1:2];

    always_comb begin
        state_next  = state;
        stall_o     = 1'b0;
        mem_we_o    = 1'b0;
        mem_wdata_o = req_i.wdata;
        case (state)
            CONV_IDLE: begin
                if (req_i.rd || partial_write) begin
                    stall_o    = 1'b1;
                    state_next = CONV_READ;
                end else if (full_write) begin
                    mem_we_o = 1'b1;
                end
            end
            CONV_READ: begin
                // Addressed word is on mem_rdata_i now
                if (partial_write) begin
                    stall_o    = 1'b1;
                    state_next = CONV_MERGE;
                end else begin
                    state_next = CONV_IDLE;
                end
            end
            CONV_MERGE: begin
                mem_we_o    = req_i.wr;
                mem_wdata_o = be_merge(held_word, req_i.wdata, req_i.be);
                state_next  = CONV_IDLE;
            end
            default: begin
                state_next = CONV_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_bus) begin
        if (reset_i) begin
            state <= CONV_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk_bus) begin
        if (state == CONV_READ) begin
            held_word <= mem_rdata_i;
        end
    end

    assign rdata_o = mem_rdata_i;

    // The merge relies on the request staying put across the stall
    a_req_stable: assert property (@(posedge clk_bus) disable iff (reset_i)
        stall_o |=> $stable(req_i))
        else $error("bytes_conv: request changed while stalled");

endmodule

// ==== source/word_ram.sv ====
`timescale 1ns/1ps

module word_ram import soc_bus_pkg::*; #(
    parameter int RAM_WORDS = 1024
) (
    input  logic                         clk_bus,
    input  logic [$clog2(RAM_WORDS)-1:0] addr_i,
    input  logic                         we_i,
    input  data_t                        wdata_i,
    output data_t                        rdata_o
);

    data_t mem [RAM_WORDS];

    // Read-first, a write returns the old word
    always_ff @(posedge clk_bus) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
        rdata_o <= mem[addr_i];
    end

endmodule

// ==== source/gpio_regs.sv ====
`timescale 1ns/1ps

module gpio_regs import soc_bus_pkg::*; (
    input  logic     clk_bus,
    input  logic     reset_i,
    input  bus_req_t req_i,
    output data_t    rdata_o,
    input  data_t    gpio_in_i,
    output data_t    gpio_out_o
);

    localparam reg_off_t OFF_OUT = 8'h00;
    localparam reg_off_t OFF_IN  = 8'h04;

    reg_off_t offset;
    data_t    out_reg;
    data_t    in_meta;
    data_t    in_sync;

    assign offset = req_i.addr[7:0];

    always_ff @(posedge clk_bus) begin
        if (reset_i) begin
            out_reg <= '0;
        end else if (req_i.wr && offset == OFF_OUT) begin
            out_reg <= be_merge(out_reg, req_i.wdata, req_i.be);
        end
    end

    // Pins are asynchronous to clk_bus
    always_ff @(posedge clk_bus) begin
        if (reset_i) begin
            in_meta <= '0;
            in_sync <= '0;
        end else begin
            in_meta <= gpio_in_i;
            in_sync <= in_meta;
        end
    end

    always_ff @(posedge clk_bus) begin
        if (reset_i) begin
            rdata_o <= '0;
        end else if (req_i.rd) begin
            case (offset)
                OFF_OUT: rdata_o <= out_reg;
                OFF_IN:  rdata_o <= in_sync;
                default: rdata_o <= '0;
            endcase
        end
    end

    assign gpio_out_o = out_reg;

endmodule

// ==== source/ticker_regs.sv ====
`timescale 1ns/1ps

module ticker_regs import soc_bus_pkg::*; (
    input  logic     clk_bus,
    input  logic     reset_i,
    input  bus_req_t req_i,
    output data_t    rdata_o,
    output logic     enable_o,
    output data_t    compare_o,
    output logic     clear_o,
    input  logic     match_i,
    input  data_t    count_i,
    output logic     irq_o
);

    localparam reg_off_t OFF_CTRL    = 8'h00;
    localparam reg_off_t OFF_COMPARE = 8'h04;
    localparam reg_off_t OFF_COUNT   = 8'h08;
    localparam reg_off_t OFF_STATUS  = 8'h0c;

    reg_off_t   offset;
    logic [1:0] ctrl;
    data_t      compare;
    logic       match_flag;
    logic       status_clr;

    assign offset     = req_i.addr[7:0];
    assign status_clr = req_i.wr && offset == OFF_STATUS && req_i.be[0] && req_i.wdata[0];

    // ctrl[0] counts, ctrl[1] lets the match through to irq_o
    always_ff @(posedge clk_bus) begin
        if (reset_i) begin
            ctrl    <= '0;
            compare <= '0;
        end else if (req_i.wr) begin
            if (offset == OFF_CTRL && req_i.be[0]) begin
                ctrl <= req_i.wdata[1:0];
            end
            if (offset == OFF_COMPARE) begin
                compare <= be_merge(compare, req_i.wdata, req_i.be);
            end
        end
    end

    // A match in the same cycle as a clear is kept
    always_ff @(posedge clk_bus) begin
        if (reset_i) begin
            match_flag <= 1'b0;
            irq_o      <= 1'b0;
        end else begin
            if (match_i) begin
                match_flag <= 1'b1;
            end else if (status_clr) begin
                match_flag <= 1'b0;
            end
            irq_o <= match_flag & ctrl[1];
        end
    end

    always_ff @(posedge clk_bus) begin
        if (reset_i) begin
            rdata_o <= '0;
        end else if (req_i.rd) begin
            case (offset)
                OFF_CTRL:    rdata_o <= {30'b0, ctrl};
                OFF_COMPARE: rdata_o <= compare;
                OFF_COUNT:   rdata_o <= count_i;
                OFF_STATUS:  rdata_o <= {31'b0, match_flag};
                default:     rdata_o <= '0;
            endcase
        end
    end

    assign enable_o  = ctrl[0];
    assign compare_o = compare;
    assign clear_o   = req_i.wr && offset == OFF_COUNT && (|req_i.be);

endmodule

// ==== source/ticker_count.sv ====
`timescale 1ns/1ps

module ticker_count import soc_bus_pkg::*; #(
    parameter int TICK_PRESCALE = 4
) (
    input  logic  clk_bus,
    input  logic  reset_i,
    input  logic  enable_i,
    input  data_t compare_i,
    input  logic  clear_i,
    output data_t count_o,
    output logic  match_o
);

    localparam int PRE_W = $clog2(TICK_PRESCALE + 1);

    logic [PRE_W-1:0] prescale;
    logic             step;

    assign step = enable_i && (prescale == PRE_W'(TICK_PRESCALE - 1));

    always_ff @(posedge clk_bus) begin
        if (reset_i || clear_i) begin
            prescale <= '0;
            count_o  <= '0;
            match_o  <= 1'b0;
        end else begin
            match_o <= 1'b0;
            // Prescaler holds while counting is off
            if (enable_i) begin
                prescale <= step ? '0 : prescale + 1'b1;
            end
            if (step) begin
                if (count_o == compare_i) begin
                    count_o <= '0;
                    match_o <= 1'b1;
                end else begin
                    count_o <= count_o + 1'b1;
                end
            end
        end
    end

    a_match_pulse: assert property (@(posedge clk_bus) disable iff (reset_i)
        match_o |=> !match_o)
        else $error("ticker_count: match held for two cycles");

endmodule

// ==== source/dbus_top.sv ====
`timescale 1ns/1ps

module dbus_top import soc_bus_pkg::*; #(
    parameter int RAM_WORDS     = 1024,
    parameter int TICK_PRESCALE = 4
) (
    input  logic     clk_bus,
    input  logic     reset_i,
    input  bus_req_t req_i,
    output data_t    rdata_o,
    output logic     stall_o,
    input  data_t    gpio_in_i,
    output data_t    gpio_out_o,
    output logic     irq_o
);

    bus_req_t ram_req;
    data_t    ram_rdata;
    logic     ram_stall;
    bus_req_t gpio_req;
    data_t    gpio_rdata;
    bus_req_t ticker_req;
    data_t    ticker_rdata;

    logic [$clog2(RAM_WORDS)-1:0] mem_addr;
    logic                         mem_we;
    data_t                        mem_wdata;
    data_t                        mem_rdata;

    logic  tick_enable;
    data_t tick_compare;
    logic  tick_clear;
    logic  tick_match;
    data_t tick_count;

    dbus_decode dbus_decode_i (
        .clk_bus        (clk_bus),
        .reset_i        (reset_i),
        .master_req_i   (req_i),
        .master_rdata_o (rdata_o),
        .master_stall_o (stall_o),
        .ram_req_o      (ram_req),
        .ram_rdata_i    (ram_rdata),
        .ram_stall_i    (ram_stall),
        .gpio_req_o     (gpio_req),
        .gpio_rdata_i   (gpio_rdata),
        .ticker_req_o   (ticker_req),
        .ticker_rdata_i (ticker_rdata)
    );

    bytes_conv #(
        .RAM_WORDS (RAM_WORDS)
    ) bytes_conv_i (
        .clk_bus     (clk_bus),
        .reset_i     (reset_i),
        .req_i       (ram_req),
        .rdata_o     (ram_rdata),
        .stall_o     (ram_stall),
        .mem_addr_o  (mem_addr),
        .mem_we_o    (mem_we),
        .mem_wdata_o (mem_wdata),
        .mem_rdata_i (mem_rdata)
    );

    word_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) word_ram_i (
        .clk_bus (clk_bus),
        .addr_i  (mem_addr),
        .we_i    (mem_we),
        .wdata_i (mem_wdata),
        .rdata_o (mem_rdata)
    );

    gpio_regs gpio_regs_i (
        .clk_bus    (clk_bus),
        .reset_i    (reset_i),
        .req_i      (gpio_req),
        .rdata_o    (gpio_rdata),
        .gpio_in_i  (gpio_in_i),
        .gpio_out_o (gpio_out_o)
    );

    ticker_regs ticker_regs_i (
        .clk_bus   (clk_bus),
        .reset_i   (reset_i),
        .req_i     (ticker_req),
        .rdata_o   (ticker_rdata),
        .enable_o  (tick_enable),
        .compare_o (tick_compare),
        .clear_o   (tick_clear),
        .match_i   (tick_match),
        .count_i   (tick_count),
        .irq_o     (irq_o)
    );

    ticker_count #(
        .TICK_PRESCALE (TICK_PRESCALE)
    ) ticker_count_i (
        .clk_bus   (clk_bus),
        .reset_i   (reset_i),
        .enable_i  (tick_enable),
        .compare_i (tick_compare),
        .clear_i   (tick_clear),
        .count_o   (tick_count),
        .match_o   (tick_match)
    );

endmodule

// ==== dv/dbus_top_tb.sv ====
`timescale 1ns/1ps

module dbus_top_tb import soc_bus_pkg::*; ();

    localparam int RAM_WORDS     = 1024;
    localparam int TICK_PRESCALE = 4;
    localparam int TICK_COMPARE  = 3;
    localparam int IDX_W         = $clog2(RAM_WORDS);
    localparam int NUM_FULL      = 64;
    localparam int NUM_PARTIAL   = 24;
    localparam int NUM_UNMAPPED  = 8;
    // Drive edge, up to two stall cycles, completing edge, one spare
    localparam int XFER_CYCLES   = 5;
    localparam int NUM_XFERS     = 2 + 2 * NUM_FULL + 2 * NUM_PARTIAL + 4 + 6
                                   + 2 + 2 * NUM_UNMAPPED;
    localparam int TICK_WAIT     = 4 * TICK_PRESCALE + 3 + 8;
    localparam int CYCLE_LIMIT   = 2 * (NUM_XFERS * XFER_CYCLES + TICK_WAIT + 8);

    logic     clk_bus;
    logic     reset_i;
    bus_req_t req_i;
    data_t    rdata_o;
    logic     stall_o;
    data_t    gpio_in_i;
    data_t    gpio_out_o;
    logic     irq_o;

    int          errors;
    int          checks;
    logic [31:0] lfsr;
    data_t       ram_model [int];
    data_t       gpio_out_model;
    data_t       gpio_in_model;
    string       name_q [$];
    data_t       exp_q [$];
    data_t       act_q [$];
    addr_t       addr_q [$];

    dbus_top #(
        .RAM_WORDS     (RAM_WORDS),
        .TICK_PRESCALE (TICK_PRESCALE)
    ) dbus_top_i (
        .clk_bus    (clk_bus),
        .reset_i    (reset_i),
        .req_i      (req_i),
        .rdata_o    (rdata_o),
        .stall_o    (stall_o),
        .gpio_in_i  (gpio_in_i),
        .gpio_out_o (gpio_out_o),
        .irq_o      (irq_o)
    );

    initial clk_bus = 1'b0;
    always #20 clk_bus = ~clk_bus;

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Model of RAM and GPIO; returns the word as it was before a write
    function automatic data_t ref_access(addr_t addr, data_t wdata, be_t be, logic is_write);
        int    idx;
        logic  is_ram;
        logic  is_gpio_out;
        data_t word;
        data_t merged;
        idx         = int'(addr[IDX_W+1:2]);
        is_ram      = (addr[31:28] == 4'h0);
        is_gpio_out = (addr[31:28] == 4'h1) && (addr[7:0] == 8'h00);
        word        = '0;
        if (is_ram) begin
            word = ram_model.exists(idx) ? ram_model[idx] : 'x;
        end else if (is_gpio_out) begin
            word = gpio_out_model;
        end else if (addr[31:28] == 4'h1 && addr[7:0] == 8'h04) begin
            word = gpio_in_model;
        end
        if (is_write && (is_ram || is_gpio_out)) begin
            merged = word;
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    merged[8*i +: 8] = wdata[8*i +: 8];
                end
            end
            if (is_ram) begin
                ram_model[idx] = merged;
            end else begin
                gpio_out_model = merged;
            end
        end
        return word;
    endfunction

    function automatic int expected_stall(addr_t addr, logic is_write, be_t be);
        if (is_write) begin
            return (addr[31:28] == 4'h0 && be != 4'hf) ? 2 : 0;
        end
        return (addr[31:28] <= 4'h2) ? 1 : 0;
    endfunction

    task automatic check_value(string name, data_t exp, data_t act);
        checks++;
        assert (act === exp)
        else begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // Request holds until stall_o drops; outputs sampled at the falling edge
    task automatic drive_transfer(bus_req_t req, output data_t data);
        int stalls;
        stalls = 0;
        @(posedge clk_bus);
        req_i <= req;
        @(negedge clk_bus);
        while (stall_o) begin
            stalls++;
            @(negedge clk_bus);
        end
        data = rdata_o;
        @(posedge clk_bus);
        req_i <= '0;
        check_value($sformatf("stall_o cycles at %h", req.addr),
                    expected_stall(req.addr, req.wr, req.be), stalls);
    endtask

    task automatic bus_write(addr_t addr, data_t wdata, be_t be);
        bus_req_t req;
        data_t    unused;
        req       = '0;
        req.addr  = addr;
        req.wdata = wdata;
        req.be    = be;
        req.wr    = 1'b1;
        drive_transfer(req, unused);
        void'(ref_access(addr, wdata, be, 1'b1));
    endtask

    task automatic bus_read(addr_t addr, output data_t data);
        bus_req_t req;
        req      = '0;
        req.addr = addr;
        req.be   = 4'hf;
        req.rd   = 1'b1;
        drive_transfer(req, data);
    endtask

    task automatic expect_read(addr_t addr, data_t exp);
        data_t act;
        bus_read(addr, act);
        name_q.push_back($sformatf("rdata_o at %h", addr));
        exp_q.push_back(exp);
        act_q.push_back(act);
    endtask

    task automatic read_and_compare(addr_t addr);
        expect_read(addr, ref_access(addr, '0, '0, 1'b0));
    endtask

    always @(posedge clk_bus) begin
        while (act_q.size() > 0) begin
            check_value(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
        end
    end

    initial begin
        int cycle_count;
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk_bus);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        data_t pins;
        addr_t a;
        be_t   be;
        int    n;
        errors         = 0;
        checks         = 0;
        lfsr           = 32'h9eea;
        gpio_out_model = '0;
        gpio_in_model  = '0;
        reset_i        = 1'b1;
        req_i          = '0;
        gpio_in_i      = '0;
        repeat (2) @(posedge clk_bus);
        reset_i <= 1'b0;

        @(negedge clk_bus);
        check_value("stall_o", '0, data_t'(stall_o));
        check_value("irq_o", '0, data_t'(irq_o));
        check_value("gpio_out_o", '0, gpio_out_o);
        read_and_compare(32'h1000_0000);
        read_and_compare(32'h2000_000c);

        while (addr_q.size() < NUM_FULL) begin
            a = rand_bits(IDX_W) << 2;
            if (!ram_model.exists(int'(a[IDX_W+1:2]))) begin
                addr_q.push_back(a);
                bus_write(a, rand_bits(32), 4'hf);
            end
        end
        // 37 is odd, so every word is visited once in a new order
        for (int i = 0; i < NUM_FULL; i++) begin
            read_and_compare(addr_q[(i * 37) % NUM_FULL]);
        end

        for (int i = 0; i < NUM_PARTIAL; i++) begin
            a  = addr_q[rand_bits($clog2(NUM_FULL))];
            be = rand_bits(4);
            if (i % 6 == 0) begin
                be = '0;
            end
            bus_write(a, rand_bits(32), be);
            read_and_compare(a);
        end

        bus_write(32'h1000_0000, rand_bits(32), 4'hf);
        bus_write(32'h1000_0000, rand_bits(32), 4'b0110);
        @(negedge clk_bus);
        check_value("gpio_out_o", gpio_out_model, gpio_out_o);
        read_and_compare(32'h1000_0000);
        pins = rand_bits(32);
        @(posedge clk_bus);
        gpio_in_i     <= pins;
        gpio_in_model  = pins;
        repeat (2) @(posedge clk_bus);
        read_and_compare(32'h1000_0004);

        bus_write(32'h2000_0004, TICK_COMPARE, 4'hf);
        bus_write(32'h2000_0000, 32'h3, 4'hf);
        n = 0;
        do begin
            @(negedge clk_bus);
            n++;
        end while (!irq_o && n <= 4 * TICK_PRESCALE + 3);
        checks++;
        assert (irq_o && n >= 3 * TICK_PRESCALE && n <= 4 * TICK_PRESCALE + 3)
        else begin
            errors++;
            $display("irq_o did not rise inside its window: irq_o=%b after %0d cycles", irq_o, n);
        end
        expect_read(32'h2000_000c, 32'h1);
        bus_write(32'h2000_000c, 32'h1, 4'hf);
        n = 0;
        do begin
            @(negedge clk_bus);
            n++;
        end while (irq_o && n < 3);
        check_value("irq_o", '0, data_t'(irq_o));
        bus_write(32'h2000_0008, 32'h0, 4'hf);
        // Prescaler restarts too, so no step lands before this read
        expect_read(32'h2000_0008, '0);

        read_and_compare(32'h3000_0010);
        read_and_compare(32'hf000_0004);
        for (int i = 0; i < NUM_UNMAPPED; i++) begin
            bus_write(32'h3000_0000 | addr_q[i], rand_bits(32), 4'hf);
        end
        for (int i = 0; i < NUM_UNMAPPED; i++) begin
            read_and_compare(addr_q[i]);
        end

        repeat (2) @(posedge clk_bus);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
source/soc_bus_pkg.sv
source/dbus_decode.sv
source/bytes_conv.sv
source/word_ram.sv
source/gpio_regs.sv
source/ticker_regs.sv
source/ticker_count.sv
source/dbus_top.sv
dv/dbus_top_tb.sv
